// ==== design/eeprom_pkg.sv ====
package eeprom_pkg;

    localparam int addr_w = 11;
    localparam int data_w = 8;
    localparam logic [3:0] dev_code = 4'b1010;  // 24Cxx device type

    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [addr_w-1:0] addr;   // [10:8] is the block select
        logic [data_w-1:0] wdata;
    } eeprom_req_t;

    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_start = 3'd1,
        op_stop  = 3'd2,
        op_send  = 3'd3,
        op_recv  = 3'd4
    } bit_op_t;

    typedef struct packed {
        bit_op_t           op;
        logic [data_w-1:0] wbyte;
        logic              master_ack;  // level driven in the ninth bit of a receive
    } bit_cmd_t;

    typedef struct packed {
        logic              done;
        logic              slave_nack;
        logic [data_w-1:0] rbyte;
    } bit_rsp_t;

    // one-hot sequencer states
    typedef enum logic [9:0] {
        idle        = 10'b00_0000_0001,
        write_start = 10'b00_0000_0010,
        ctrl_write  = 10'b00_0000_0100,
        addr_write  = 10'b00_0000_1000,
        data_write  = 10'b00_0001_0000,
        read_start  = 10'b00_0010_0000,
        ctrl_read   = 10'b00_0100_0000,
        data_read   = 10'b00_1000_0000,
        stop        = 10'b01_0000_0000,
        ackn        = 10'b10_0000_0000
    } main_state_t;

endpackage

// ==== design/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module eeprom_bit_engine (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bit_cmd_t cmd,
    input  logic                 sda_in,
    output eeprom_pkg::bit_rsp_t rsp,
    output logic                 scl,
    output logic                 sda_pull
);

    logic                          busy;
    eeprom_pkg::bit_op_t           op_q;
    logic [4:0]                    phase;       // one scl phase per CLK
    logic [eeprom_pkg::data_w-1:0] tx_q;
    logic                          mack_q;
    logic                          sda_d;       // launched half a cycle later
    logic                          done_q;
    logic                          nack_q;
    logic [eeprom_pkg::data_w-1:0] rx_q;
    logic [3:0]                    bit_i;
    logic                          short_op;
    logic                          last_phase;

    function automatic logic scl_level(eeprom_pkg::bit_op_t op, logic [4:0] p);
        logic lvl;
        case (op)
            eeprom_pkg::op_start: lvl = p[0] ^ p[1];  // low high high low
            eeprom_pkg::op_stop:  lvl = p[0] | p[1];  // low high high high
            default:              lvl = p[0];         // low then high per bit
        endcase
        return lvl;
    endfunction

    // returns 1 when the master pulls sda low
    function automatic logic sda_level(eeprom_pkg::bit_op_t op, logic [4:0] p,
                                       logic [7:0] tx, logic mack);
        logic [3:0] b;
        logic       lvl;
        b = p[4:1];
        case (op)
            eeprom_pkg::op_start: lvl = p[1];
            eeprom_pkg::op_stop:  lvl = ~p[1];
            eeprom_pkg::op_send:  lvl = (b < 4'd8) ? ~tx[3'd7 - b[2:0]] : 1'b0;  // ack slot released
            eeprom_pkg::op_recv:  lvl = (b == 4'd8) && !mack;
            default:              lvl = 1'b0;
        endcase
        return lvl;
    endfunction

    assign bit_i      = phase[4:1];
    assign short_op   = (op_q == eeprom_pkg::op_start) || (op_q == eeprom_pkg::op_stop);
    assign last_phase = short_op ? (phase == 5'd3) : (phase == 5'd17);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy   <= 1'b0;
            op_q   <= eeprom_pkg::op_none;
            phase  <= 5'd0;
            scl    <= 1'b1;  // bus idle
            sda_d  <= 1'b0;
            done_q <= 1'b0;
            nack_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy) begin
                if (cmd_valid && cmd.op == eeprom_pkg::op_none) begin
                    done_q <= 1'b1;
                end else if (cmd_valid) begin
                    busy   <= 1'b1;
                    op_q   <= cmd.op;
                    phase  <= 5'd0;
                    nack_q <= 1'b0;
                    scl    <= scl_level(cmd.op, 5'd0);
                    sda_d  <= sda_level(cmd.op, 5'd0, cmd.wbyte, cmd.master_ack);
                end
            end else if (last_phase) begin
                busy   <= 1'b0;
                done_q <= 1'b1;
                if (op_q == eeprom_pkg::op_send)
                    nack_q <= sda_in;  // slave ack sampled with scl high
            end else begin
                phase <= phase + 5'd1;
                scl   <= scl_level(op_q, phase + 5'd1);
                sda_d <= sda_level(op_q, phase + 5'd1, tx_q, mack_q);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!busy && cmd_valid) begin
            tx_q   <= cmd.wbyte;
            mack_q <= cmd.master_ack;
        end
        // shift in at the end of each scl high phase
        if (busy && op_q == eeprom_pkg::op_recv && phase[0] && bit_i < 4'd8)
            rx_q <= {rx_q[6:0], sda_in};
    end

    // sda moves mid-cycle clear of the scl edges
    always_ff @(negedge CLK) begin
        if (RESET)
            sda_pull <= 1'b0;
        else
            sda_pull <= sda_d;
    end

    assign rsp = '{done: done_q, slave_nack: nack_q, rbyte: rx_q};

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && !(busy && short_op)) |-> !$changed(sda_pull));

    // sequencer must wait for done
    a_no_cmd_busy: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !busy);

endmodule

// ==== design/eeprom_wr.sv ====
`timescale 1ns/1ps

module eeprom_wr (
    input  logic                          CLK,
    input  logic                          RESET,
    input  eeprom_pkg::eeprom_req_t       req,
    input  eeprom_pkg::bit_rsp_t          rsp,
    output logic                          ack,
    output logic                          err,
    output logic [eeprom_pkg::data_w-1:0] rdata,
    output logic                          cmd_valid,
    output eeprom_pkg::bit_cmd_t          cmd
);

    eeprom_pkg::main_state_t       state;
    eeprom_pkg::main_state_t       state_n;
    eeprom_pkg::bit_cmd_t          cmd_n;
    logic                          issue;
    logic                          armed;     // request seen low since last transfer
    logic                          is_read;
    logic                          err_q;
    logic [eeprom_pkg::addr_w-1:0] addr_q;
    logic [eeprom_pkg::data_w-1:0] wdata_q;
    logic [7:0]                    ctrl_wr;
    logic [7:0]                    ctrl_rd;
    logic                          req_any;
    logic                          sending;
    logic                          start_xfer;
    logic                          nack_hit;

    assign req_any = req.wr || req.rd;
    assign ctrl_wr = {eeprom_pkg::dev_code, addr_q[eeprom_pkg::addr_w-1:8], 1'b0};
    assign ctrl_rd = {eeprom_pkg::dev_code, addr_q[eeprom_pkg::addr_w-1:8], 1'b1};
    assign sending = (state == eeprom_pkg::ctrl_write) || (state == eeprom_pkg::addr_write) ||
                     (state == eeprom_pkg::data_write) || (state == eeprom_pkg::ctrl_read);

    always_comb begin
        state_n    = state;
        issue      = 1'b0;
        cmd_n      = '{op: eeprom_pkg::op_none, wbyte: '0, master_ack: 1'b0};
        start_xfer = 1'b0;
        nack_hit   = 1'b0;
        case (state)
            eeprom_pkg::idle: begin
                if (armed && req_any) begin
                    start_xfer = 1'b1;
                    issue      = 1'b1;
                    cmd_n.op   = eeprom_pkg::op_start;
                    state_n    = eeprom_pkg::write_start;
                end
            end
            eeprom_pkg::write_start: begin
                if (rsp.done) begin
                    issue       = 1'b1;
                    cmd_n.op    = eeprom_pkg::op_send;
                    cmd_n.wbyte = ctrl_wr;
                    state_n     = eeprom_pkg::ctrl_write;
                end
            end
            eeprom_pkg::ctrl_write: begin
                if (rsp.done) begin
                    issue       = 1'b1;
                    cmd_n.op    = eeprom_pkg::op_send;
                    cmd_n.wbyte = addr_q[7:0];  // word address
                    state_n     = eeprom_pkg::addr_write;
                end
            end
            eeprom_pkg::addr_write: begin
                if (rsp.done && is_read) begin
                    issue    = 1'b1;
                    cmd_n.op = eeprom_pkg::op_start;  // repeated start
                    state_n  = eeprom_pkg::read_start;
                end else if (rsp.done) begin
                    issue       = 1'b1;
                    cmd_n.op    = eeprom_pkg::op_send;
                    cmd_n.wbyte = wdata_q;
                    state_n     = eeprom_pkg::data_write;
                end
            end
            eeprom_pkg::read_start: begin
                if (rsp.done) begin
                    issue       = 1'b1;
                    cmd_n.op    = eeprom_pkg::op_send;
                    cmd_n.wbyte = ctrl_rd;
                    state_n     = eeprom_pkg::ctrl_read;
                end
            end
            eeprom_pkg::ctrl_read: begin
                if (rsp.done) begin
                    issue            = 1'b1;
                    cmd_n.op         = eeprom_pkg::op_recv;
                    cmd_n.master_ack = 1'b1;  // nack the only byte
                    state_n          = eeprom_pkg::data_read;
                end
            end
            eeprom_pkg::data_write,
            eeprom_pkg::data_read: begin
                if (rsp.done) begin
                    issue    = 1'b1;
                    cmd_n.op = eeprom_pkg::op_stop;
                    state_n  = eeprom_pkg::stop;
                end
            end
            eeprom_pkg::stop: begin
                if (rsp.done)
                    state_n = eeprom_pkg::ackn;
            end
            default: state_n = eeprom_pkg::idle;  // ackn lasts one cycle
        endcase

        // slave nack ends the transfer with a stop
        if (sending && rsp.done && rsp.slave_nack) begin
            nack_hit = 1'b1;
            issue    = 1'b1;
            cmd_n    = '{op: eeprom_pkg::op_stop, wbyte: '0, master_ack: 1'b0};
            state_n  = eeprom_pkg::stop;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= eeprom_pkg::idle;
            cmd_valid <= 1'b0;
            armed     <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            state     <= state_n;
            cmd_valid <= issue;
            if (!req_any)
                armed <= 1'b1;
            else if (start_xfer)
                armed <= 1'b0;
            if (start_xfer)
                err_q <= 1'b0;
            else if (nack_hit)
                err_q <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        cmd <= cmd_n;
        if (start_xfer) begin
            is_read <= req.rd;
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
        end
        if (state == eeprom_pkg::data_read && rsp.done)
            rdata <= rsp.rbyte;
    end

    assign ack = (state == eeprom_pkg::ackn);
    assign err = err_q;

    // single pulse and no restart on a request still held
    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack && !start_xfer);

    a_state_onehot: assert property (@(posedge CLK) disable iff (RESET) $onehot(state));

    a_req_excl: assert property (@(posedge CLK) disable iff (RESET) !(req.wr && req.rd));

endmodule

// ==== design/eeprom_top.sv ====
`timescale 1ns/1ps

module eeprom_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  eeprom_pkg::eeprom_req_t       req,
    input  logic                          sda_in,    // resolved bus level
    output logic                          ack,
    output logic                          err,
    output logic [eeprom_pkg::data_w-1:0] rdata,
    output logic                          scl,
    output logic                          sda_pull   // high pulls sda low
);

    logic                 cmd_valid;
    eeprom_pkg::bit_cmd_t cmd;
    eeprom_pkg::bit_rsp_t rsp;

    eeprom_wr seq_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .rsp       (rsp),
        .ack       (ack),
        .err       (err),
        .rdata     (rdata),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    eeprom_bit_engine engine_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .sda_in    (sda_in),
        .rsp       (rsp),
        .scl       (scl),
        .sda_pull  (sda_pull)
    );

endmodule

// ==== bench/eeprom_model.sv ====
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,    // resolved bus line
    output logic pull    // high pulls sda low
);

    typedef enum logic [2:0] {m_idle, m_ctrl, m_word, m_wdata, m_rdata} mode_t;

    logic [7:0]  mem [2048] = '{default: 8'h00};
    mode_t       mode = m_idle;
    logic [3:0]  cnt = 4'd0;     // scl rising edges in this byte
    logic [7:0]  sh = 8'h00;
    logic [7:0]  rbyte = 8'h00;
    logic [2:0]  blk = 3'd0;
    logic        rnw = 1'b0;
    logic [10:0] ptr = 11'd0;
    logic        pull_q = 1'b0;
    logic        scl_q = 1'b1;
    logic        sda_q = 1'b1;

    assign pull = pull_q;

    always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
        if (scl && scl_q && sda_q && !sda) begin  // start or repeated start
            mode   = m_ctrl;
            cnt    = 4'd0;
            pull_q = 1'b0;
        end else if (scl && scl_q && !sda_q && sda) begin  // stop
            mode   = m_idle;
            pull_q = 1'b0;
        end else if (scl && !scl_q && mode != m_idle) begin
            if (cnt < 4'd8)
                sh = {sh[6:0], sda};
            cnt = cnt + 4'd1;
        end else if (!scl && scl_q && mode != m_idle) begin
            if (cnt == 4'd8) begin
                case (mode)
                    m_ctrl: begin
                        // block 7 is not populated
                        if (sh[7:4] == 4'b1010 && sh[3:1] != 3'd7) begin
                            blk    = sh[3:1];
                            rnw    = sh[0];
                            pull_q = 1'b1;
                        end else begin
                            mode   = m_idle;
                            pull_q = 1'b0;
                        end
                    end
                    m_word: begin
                        ptr    = {blk, sh};
                        pull_q = 1'b1;
                    end
                    m_wdata: begin
                        mem[ptr] = sh;
                        pull_q   = 1'b1;
                    end
                    default: pull_q = 1'b0;  // master's ack slot
                endcase
            end else if (cnt == 4'd9) begin
                cnt    = 4'd0;
                pull_q = 1'b0;
                case (mode)
                    m_ctrl:  mode = rnw ? m_rdata : m_word;
                    m_word:  mode = m_wdata;
                    default: mode = m_idle;
                endcase
                if (mode == m_rdata) begin
                    rbyte  = mem[ptr];
                    pull_q = !rbyte[7];
                end
            end else if (mode == m_rdata) begin
                pull_q = !rbyte[3'd7 - cnt[2:0]];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== bench/eeprom_checker.sv ====
`timescale 1ns/1ps

module eeprom_checker (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         ack,
    input  logic         err,
    input  logic [7:0]   rdata,
    input  logic         pending,    // a request is outstanding
    input  logic [127:0] exp_name,
    input  logic         exp_read,
    input  logic [7:0]   exp_rdata,
    input  logic         exp_err,
    output int           fails,
    output int           passes,
    output int           acks
);

    int   fail_n = 0;
    int   pass_n = 0;
    int   ack_n = 0;
    logic bad;

    assign fails  = fail_n;
    assign passes = pass_n;
    assign acks   = ack_n;

    always @(posedge CLK) begin
        if (!RESET && ack) begin
            ack_n <= ack_n + 1;
            // read data only matters on a clean read
            bad = (err !== exp_err) || (exp_read && !exp_err && rdata !== exp_rdata);
            if (!pending) begin
                $display("extra acknowledge from the DUT with no request outstanding");
                fail_n <= fail_n + 1;
            end else if (bad && exp_read) begin
                $display("FAILED %0s: expected err %0b rdata %02h, actual err %0b rdata %02h",
                         exp_name, exp_err, exp_rdata, err, rdata);
                fail_n <= fail_n + 1;
            end else if (bad) begin
                $display("FAILED %0s: expected err %0b, actual err %0b",
                         exp_name, exp_err, err);
                fail_n <= fail_n + 1;
            end else begin
                $display("passed %0s", exp_name);
                pass_n <= pass_n + 1;
            end
        end
    end

endmodule

// ==== bench/tb_eeprom.sv ====
`timescale 1ns/1ps

module tb_eeprom;

    logic                    CLK;
    logic                    RESET;
    eeprom_pkg::eeprom_req_t req;
    logic                    ack;
    logic                    err;
    logic [7:0]              rdata;
    logic                    scl;
    logic                    sda_pull;
    logic                    slave_pull;
    logic                    sda_line;

    logic [127:0] names [64];
    logic         is_rd [64];
    logic [10:0]  addrs [64];
    logic [7:0]   wdat [64];
    logic [7:0]   rdat [64];
    logic         errs [64];
    int           n_tests = 0;
    int           limit = 0;
    int           cycles = 0;
    logic [5:0]   idx;
    logic         pending;
    logic         ok;
    int           fails;
    int           passes;
    int           acks;

    assign sda_line = !(sda_pull || slave_pull);  // open drain with pull-up

    eeprom_top eeprom_top_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .sda_in   (sda_line),
        .ack      (ack),
        .err      (err),
        .rdata    (rdata),
        .scl      (scl),
        .sda_pull (sda_pull)
    );

    eeprom_model model_i (
        .scl  (scl),
        .sda  (sda_line),
        .pull (slave_pull)
    );

    eeprom_checker checker_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .ack       (ack),
        .err       (err),
        .rdata     (rdata),
        .pending   (pending),
        .exp_name  (names[idx]),
        .exp_read  (is_rd[idx]),
        .exp_rdata (rdat[idx]),
        .exp_err   (errs[idx]),
        .fails     (fails),
        .passes    (passes),
        .acks      (acks)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) cycles <= cycles + 1;

    task automatic load_golden(output logic found);
        int           fd;
        int           got;
        string        line;
        logic [127:0] nm;
        logic [7:0]   opc;
        logic [31:0]  a, wd, rd, e;
        found = 1'b0;
        fd = $fopen("bench/eeprom_golden.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                // comment lines fail the scan
                got = $sscanf(line, "%s %s %h %h %h %h", nm, opc, a, wd, rd, e);
                if (got == 6 && n_tests < 64) begin
                    names[n_tests[5:0]] = nm;
                    is_rd[n_tests[5:0]] = (opc == "R");
                    addrs[n_tests[5:0]] = a[10:0];
                    wdat[n_tests[5:0]]  = wd[7:0];
                    rdat[n_tests[5:0]]  = rd[7:0];
                    errs[n_tests[5:0]]  = e[0];
                    n_tests++;
                end
            end
            $fclose(fd);
            found = (n_tests > 0);
        end
    endtask

    // hold the request until ack and then idle two cycles
    task automatic run_transfer(input logic [5:0] k);
        idx     <= k;
        pending <= 1'b1;
        req     <= '{wr: !is_rd[k], rd: is_rd[k], addr: addrs[k], wdata: wdat[k]};
        do
            @(posedge CLK);
        while (!ack);
        req     <= '0;
        pending <= 1'b0;
        repeat (2) @(posedge CLK);
    endtask

    initial begin
        RESET   = 1'b1;
        req     = '0;
        idx     = 6'd0;
        pending = 1'b0;
        load_golden(ok);
        if (!ok) begin
            $display("no test could be read from bench/eeprom_golden.txt");
            $display("Finished with errors");
            $finish;
        end else begin
            limit = 150 * n_tests + 100;
            repeat (3) @(posedge CLK);
            RESET <= 1'b0;
            repeat (2) @(posedge CLK);  // sequencer arms on a low request
            for (int i = 0; i < n_tests; i++)
                run_transfer(i[5:0]);
            repeat (5) @(posedge CLK);  // room for a stray ack
            if (acks != n_tests)
                $display("expected %0d acknowledges but the DUT gave %0d", n_tests, acks);
            $display("%0d tests, %0d passed, %0d failed", n_tests, passes, fails);
            if (fails == 0 && passes == n_tests && acks == n_tests)
                $display("Finished with no errors");
            else
                $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        while (limit == 0 || cycles < limit)
            @(posedge CLK);
        $display("DUT stopped answering, no acknowledge after %0d cycles", cycles);
        $display("%0d tests, %0d passed, %0d failed", n_tests, passes, fails + 1);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== bench/eeprom_golden.txt ====
# columns: test name, op (W write, R read), hex address, hex write data,
# then the hex read data and the err bit that the DUT should return
unwritten_000  R 000 00 00 0
unwritten_5ff  R 5ff 00 00 0
wr_a           W 012 a5 00 0
rd_a           R 012 00 a5 0
wr_b           W 2c7 3c 00 0
rd_b           R 2c7 00 3c 0
blk0_wr        W 034 11 00 0
blk3_wr        W 334 33 00 0
blk6_wr        W 634 66 00 0
blk0_rd        R 034 00 11 0
blk3_rd        R 334 00 33 0
blk6_rd        R 634 00 66 0
ovw_first      W 1f0 de 00 0
ovw_second     W 1f0 ad 00 0
ovw_rd         R 1f0 00 ad 0
blk7_wr        W 734 77 00 1
blk7_rd        R 734 00 00 1
after_blk7_rd  R 334 00 33 0
blk7_rd_top    R 7ff 00 00 1
top_wr         W 6ff ff 00 0
top_rd         R 6ff 00 ff 0
unwritten_635  R 635 00 00 0

// ==== filelist.f ====
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_wr.sv
design/eeprom_top.sv
bench/eeprom_model.sv
bench/eeprom_checker.sv
bench/tb_eeprom.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the eeprom testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_eeprom \
    -f filelist.f --Mdir obj_dir -o sim_eeprom
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_eeprom > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
echo "pass line missing from sim.log"
exit 1
